/* dataMemory.sv */
`timescale 1ns/1ps

module dataMemory
  import lsuMemPkg::*;
(
  input  logic                   Clk,
  input  logic                   rstN,
  input  logic [memIdxWidth-1:0] memIdx,
  input  memWord_u               memWrData,
  input  logic [byteEnWidth-1:0] memByteEn,
  input  logic                   memWrite,
  input  logic                   memRead,
  output memWord_u               memRdData
);

  memWord_u mem [memDepth];

  ////////////////////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////////////////////

  // Whole array zeroed by reset
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < memDepth; i++) begin
        mem[i] <= '0;
      end
    end else if (memWrite) begin
      // Only enabled lanes change
      for (int b = 0; b < byteEnWidth; b++) begin
        if (memByteEn[b]) begin
          mem[memIdx].bytes[b] <= memWrData.bytes[b];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read port
  ////////////////////////////////////////////////////////////////////////////

  // Registered read, holds its value between loads
  // A write at the same edge is not seen until the next read
  always_ff @(posedge Clk) begin
    if (memRead) begin
      memRdData <= mem[memIdx];
    end
  end

endmodule

/* loadExtractStage.sv */
`timescale 1ns/1ps

module loadExtractStage
  import mipsIsaPkg::*;
  import lsuMemPkg::*;
(
  input  logic                    Clk,
  input  logic                    rstN,
  input  logic                    aValid,
  input  logic                    aUnsigned,
  input  logic [1:0]              aWidth,
  input  logic [laneSelWidth-1:0] aLane,
  input  logic [regIdxWidth-1:0]  aReg,
  input  memWord_u                aReadWord,
  output logic                    loadValid,
  output logic [dataWidth-1:0]    loadData,
  output logic [regIdxWidth-1:0]  loadReg
);

  logic [byteWidth-1:0] laneByte;
  logic [halfWidth-1:0] laneHalf;
  logic                 byteFill;
  logic                 halfFill;
  logic [dataWidth-1:0] extended;

  ////////////////////////////////////////////////////////////////////////////
  // Lane select and extension
  ////////////////////////////////////////////////////////////////////////////

  // Byte by full lane, half by lane bit 1
  assign laneByte = aReadWord.bytes[aLane];
  assign laneHalf = aReadWord.halves[aLane[1]];

  // Fill bit is the sign bit, or zero for LBU/LHU
  assign byteFill = laneByte[byteWidth-1] & ~aUnsigned;
  assign halfFill = laneHalf[halfWidth-1] & ~aUnsigned;

  always_comb begin
    case (aWidth)
      widthByte: extended = {{(dataWidth-byteWidth){byteFill}}, laneByte};
      widthHalf: extended = {{(dataWidth-halfWidth){halfFill}}, laneHalf};
      // word goes through untouched
      default:   extended = aReadWord.word;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      loadValid <= 1'b0;
    end else begin
      loadValid <= aValid;
    end
  end

  always_ff @(posedge Clk) begin
    loadData <= extended;
    loadReg  <= aReg;
  end

  // Width code 11 must never reach a live load
  knownWidth: assert property (@(posedge Clk) disable iff (!rstN)
    aValid |-> (aWidth != 2'b11));

endmodule

/* loadStorePipe.f */
mipsIsaPkg.sv
lsuMemPkg.sv
dataMemory.sv
memDecodeStage.sv
memAccessStage.sv
loadExtractStage.sv
loadStorePipe.sv
tbClock.sv
loadStorePipe_tb.sv

/* loadStorePipe.sv */
`timescale 1ns/1ps

module loadStorePipe
  import mipsIsaPkg::*;
  import lsuMemPkg::*;
(
  input  logic                   Clk,
  input  logic                   rstN,
  input  logic                   instValid,
  input  logic [instWidth-1:0]   instWord,
  input  logic [dataWidth-1:0]   baseValue,
  input  logic [dataWidth-1:0]   storeValue,
  output logic                   loadValid,
  output logic [dataWidth-1:0]   loadData,
  output logic [regIdxWidth-1:0] loadReg
);

  // Decode to access
  logic                    dValid;
  logic                    dIsStore;
  logic                    dIsLoad;
  logic                    dUnsigned;
  logic [1:0]              dWidth;
  logic [dataWidth-1:0]    dAddr;
  logic [dataWidth-1:0]    dStoreValue;
  logic [regIdxWidth-1:0]  dReg;

  // Access to extract
  logic                    aValid;
  logic                    aUnsigned;
  logic [1:0]              aWidth;
  logic [laneSelWidth-1:0] aLane;
  logic [regIdxWidth-1:0]  aReg;
  memWord_u                aReadWord;

  ////////////////////////////////////////////////////////////////////////////
  // Three stages, one register each
  ////////////////////////////////////////////////////////////////////////////

  memDecodeStage u_memDecodeStage (
    .Clk(Clk), .rstN(rstN), .instValid(instValid), .instWord(instWord),
    .baseValue(baseValue), .storeValue(storeValue), .dValid(dValid),
    .dIsStore(dIsStore), .dIsLoad(dIsLoad), .dUnsigned(dUnsigned), .dWidth(dWidth),
    .dAddr(dAddr), .dStoreValue(dStoreValue), .dReg(dReg)
  );

  // Holds the data memory
  memAccessStage u_memAccessStage (
    .Clk(Clk), .rstN(rstN), .dValid(dValid), .dIsStore(dIsStore), .dIsLoad(dIsLoad),
    .dUnsigned(dUnsigned), .dWidth(dWidth), .dAddr(dAddr), .dStoreValue(dStoreValue),
    .dReg(dReg), .aValid(aValid), .aUnsigned(aUnsigned), .aWidth(aWidth),
    .aLane(aLane), .aReg(aReg), .aReadWord(aReadWord)
  );

  loadExtractStage u_loadExtractStage (
    .Clk(Clk), .rstN(rstN), .aValid(aValid), .aUnsigned(aUnsigned), .aWidth(aWidth),
    .aLane(aLane), .aReg(aReg), .aReadWord(aReadWord), .loadValid(loadValid),
    .loadData(loadData), .loadReg(loadReg)
  );

endmodule

/* loadStorePipe_tb.sv */
`timescale 1ns/1ps

module loadStorePipe_tb
  import mipsIsaPkg::*;
  import lsuMemPkg::*;
();

  localparam int clkPeriod   = 4;
  localparam int numDirected = 17;
  localparam int numRandom   = 600;

  logic                   Clk;
  logic                   rstN;
  logic                   instValid;
  logic [instWidth-1:0]   instWord;
  logic [dataWidth-1:0]   baseValue;
  logic [dataWidth-1:0]   storeValue;
  logic                   loadValid;
  logic [dataWidth-1:0]   loadData;
  logic [regIdxWidth-1:0] loadReg;

  integer seed;
  int     negCount;

  // Little-endian byte image of the whole data memory
  logic [byteWidth-1:0] modelMem [memDepth*byteEnWidth];

  // Outstanding loads with the oldest at the head
  logic [dataWidth-1:0]   expData  [$];
  logic [regIdxWidth-1:0] expReg   [$];
  int                     expCycle [$];
  string                  expName  [$];

  tbClock u_tbClock (.Clk(Clk), .rstN(rstN));

  loadStorePipe u_loadStorePipe (
    .Clk(Clk), .rstN(rstN), .instValid(instValid), .instWord(instWord),
    .baseValue(baseValue), .storeValue(storeValue), .loadValid(loadValid),
    .loadData(loadData), .loadReg(loadReg)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Failure and compare
  ////////////////////////////////////////////////////////////////////////////

  task automatic abortRun(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic checkValue(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      abortRun($sformatf("[ERROR] %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model
  ////////////////////////////////////////////////////////////////////////////

  // Address is aligned so OR-ing the lane bits walks the bytes upward
  function automatic logic [31:0] modelLoad(input logic [5:0] op, input logic [9:0] a);
    logic [15:0] half;
    logic [7:0]  oneByte;
    logic [31:0] result;
    oneByte = modelMem[a];
    half    = {modelMem[a | 10'd1], modelMem[a]};
    case (op)
      opLb:    result = {{24{oneByte[7]}}, oneByte};
      opLbu:   result = {24'h0, oneByte};
      opLh:    result = {{16{half[15]}}, half};
      opLhu:   result = {16'h0, half};
      default: result = {modelMem[a | 10'd3], modelMem[a | 10'd2], half};
    endcase
    return result;
  endfunction

  // Only the low byte or half of rt lands in memory
  task automatic modelStore(input logic [5:0] op, input logic [9:0] a,
                            input logic [31:0] val);
    modelMem[a] = val[7:0];
    if (op != opSb) begin
      modelMem[a | 10'd1] = val[15:8];
    end
    if (op == opSw) begin
      modelMem[a | 10'd2] = val[23:16];
      modelMem[a | 10'd3] = val[31:24];
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  // One instruction per rising edge with base + offset landing on addr
  task automatic issueInst(input logic [5:0] op, input logic [4:0] rt,
                           input logic [31:0] addr, input logic [31:0] stVal,
                           input string name);
    logic [15:0] offset;
    logic [31:0] base;
    logic [9:0]  a;
    offset = 16'($random(seed));
    base   = addr - {{16{offset[15]}}, offset};
    a      = addr[9:0];
    @(posedge Clk);
    instValid  <= 1'b1;
    instWord   <= {op, 5'($random(seed)), rt, offset};
    baseValue  <= base;
    storeValue <= stVal;
    case (op)
      opSb, opSh, opSw: modelStore(op, a, stVal);
      opLb, opLh, opLw, opLbu, opLhu: begin
        // Result due on the third edge after this one
        expData.push_back(modelLoad(op, a));
        expReg.push_back(rt);
        expCycle.push_back(negCount + 4);
        expName.push_back(name);
      end
      default: ;
    endcase
  endtask

  task automatic idleSlot();
    @(posedge Clk);
    instValid <= 1'b0;
    instWord  <= 32'($random(seed));
  endtask

  // Eight memory opcodes, an unknown one, or an idle cycle
  task automatic randomSlot();
    int          pick;
    logic [5:0]  op;
    logic [1:0]  lane;
    logic [31:0] addr;
    pick = {$random(seed)} % 10;
    lane = 2'($random(seed));
    case (pick)
      0:       op = opLb;
      1:       op = opLh;
      2:       op = opLw;
      3:       op = opLbu;
      4:       op = opLhu;
      5:       op = opSb;
      6:       op = opSh;
      7:       op = opSw;
      // 0x00 to 0x0F hold no memory opcode
      default: op = {2'b00, 4'($random(seed))};
    endcase
    if (op == opLh || op == opLhu || op == opSh) begin
      lane[0] = 1'b0;
    end else if (op != opLb && op != opLbu && op != opSb) begin
      lane = 2'b00;
    end
    // Only 64 words so loads often find earlier stores
    addr = {24'h0, 6'($random(seed)), lane};
    if (pick == 9) begin
      idleSlot();
    end else begin
      issueInst(op, 5'($random(seed)), addr, 32'($random(seed)), "random");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Output monitor on the falling edge
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge Clk) begin
    negCount = negCount + 1;
    if (rstN) begin
      if (loadValid) begin
        if (expData.size() == 0) begin
          abortRun("loadValid was raised while no load was outstanding");
        end else begin
          checkValue({expName[0], " loadData"}, expData[0], loadData);
          checkValue({expName[0], " loadReg"}, {27'b0, expReg[0]}, {27'b0, loadReg});
          checkValue({expName[0], " latency"}, 32'(expCycle[0]), 32'(negCount));
          void'(expData.pop_front());
          void'(expReg.pop_front());
          void'(expCycle.pop_front());
          void'(expName.pop_front());
        end
      end else if (expCycle.size() != 0 && expCycle[0] < negCount) begin
        abortRun("An issued load never raised loadValid");
      end
    end
  end

  // Budget of one cycle per slot plus drain margin
  initial begin
    @(posedge rstN);
    #((numDirected + numRandom + 20) * clkPeriod);
    abortRun("Timeout, the run did not finish in the expected time");
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed       = 32'h9f8657a1;
    negCount   = 0;
    instValid  = 1'b0;
    instWord   = '0;
    baseValue  = '0;
    storeValue = '0;
    for (int i = 0; i < memDepth * byteEnWidth; i++) begin
      modelMem[i] = '0;
    end
    @(posedge rstN);

    // Untouched word reads back zero
    issueInst(opLw, 5'd1, 32'h80, 32'h0, "reset state LW");
    // Store then load on the very next cycle
    issueInst(opSw, 5'd2, 32'h84, 32'hDEADBEEF, "round trip SW");
    issueInst(opLw, 5'd3, 32'h84, 32'h0, "round trip LW");
    // One byte per lane while the upper bits of rt stay out
    issueInst(opSb, 5'd4, 32'h88, 32'hAAAAAA11, "byte placement SB");
    issueInst(opSb, 5'd4, 32'h89, 32'hBBBBBB82, "byte placement SB");
    issueInst(opSb, 5'd4, 32'h8A, 32'hCCCCCC33, "byte placement SB");
    issueInst(opSb, 5'd4, 32'h8B, 32'hDDDDDDF4, "byte placement SB");
    issueInst(opLw, 5'd5, 32'h88, 32'h0, "byte placement LW");
    issueInst(opLb, 5'd6, 32'h89, 32'h0, "sign extend LB");
    issueInst(opLbu, 5'd7, 32'h89, 32'h0, "zero extend LBU");
    // Both halves with the sign bit set in the low one
    issueInst(opSh, 5'd8, 32'h8C, 32'h55558001, "half placement SH");
    issueInst(opSh, 5'd8, 32'h8E, 32'h66661234, "half placement SH");
    issueInst(opLh, 5'd9, 32'h8C, 32'h0, "sign extend LH");
    issueInst(opLhu, 5'd10, 32'h8C, 32'h0, "zero extend LHU");
    issueInst(opLw, 5'd11, 32'h8C, 32'h0, "half placement LW");
    // Bubble must leave the word intact
    issueInst(6'h3F, 5'd12, 32'h84, 32'h01234567, "bubble");
    issueInst(opLw, 5'd13, 32'h84, 32'h0, "bubble LW");

    for (int i = 0; i < numRandom; i++) begin
      randomSlot();
    end
    @(posedge Clk);
    instValid <= 1'b0;

    // Drain the pipe, then leave room for a stray strobe
    while (expData.size() != 0) begin
      @(posedge Clk);
    end
    repeat (4) @(posedge Clk);

    $display("Test OK");
    $finish;
  end

endmodule

/* lsuMemPkg.sv */
package lsuMemPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Data memory geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int dataWidth    = 32;
  localparam int byteWidth    = 8;
  localparam int halfWidth    = 16;

  // 256 words, indexed by address bits [9:2]
  localparam int memDepth     = 256;
  localparam int memIdxWidth  = 8;

  // One enable per byte lane
  localparam int byteEnWidth  = dataWidth / byteWidth;

  // Byte lane within a word, address bits [1:0]
  localparam int laneSelWidth = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Memory word views
  ////////////////////////////////////////////////////////////////////////////

  // Same 32 bits, seen as a word, as byte lanes or as halfwords
  // bytes[0] and halves[0] are the low end of the word
  typedef union packed {
    logic [dataWidth-1:0]                              word;
    logic [byteEnWidth-1:0][byteWidth-1:0]             bytes;
    logic [dataWidth/halfWidth-1:0][halfWidth-1:0]     halves;
  } memWord_u;

endpackage

/* memAccessStage.sv */
`timescale 1ns/1ps

module memAccessStage
  import mipsIsaPkg::*;
  import lsuMemPkg::*;
(
  input  logic                    Clk,
  input  logic                    rstN,
  input  logic                    dValid,
  input  logic                    dIsStore,
  input  logic                    dIsLoad,
  input  logic                    dUnsigned,
  input  logic [1:0]              dWidth,
  input  logic [31:0]             dAddr,
  input  logic [31:0]             dStoreValue,
  input  logic [regIdxWidth-1:0]  dReg,
  output logic                    aValid,
  output logic                    aUnsigned,
  output logic [1:0]              aWidth,
  output logic [laneSelWidth-1:0] aLane,
  output logic [regIdxWidth-1:0]  aReg,
  output memWord_u                aReadWord
);

  logic [laneSelWidth-1:0] lane;
  logic [memIdxWidth-1:0]  memIdx;
  memWord_u                memWrData;
  logic [byteEnWidth-1:0]  memByteEn;
  logic                    memWrite;
  logic                    memRead;

  assign lane   = dAddr[laneSelWidth-1:0];
  // Low address bits are dropped, index wraps at memDepth
  assign memIdx = dAddr[memIdxWidth+laneSelWidth-1:laneSelWidth];

  assign memWrite = dValid & dIsStore;
  assign memRead  = dValid & dIsLoad;

  ////////////////////////////////////////////////////////////////////////////
  // Store placement
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    memWrData = '0;
    memByteEn = '0;
    case (dWidth)
      widthWord: begin
        memWrData.word = dStoreValue;
        memByteEn      = 4'b1111;
      end
      widthHalf: begin
        // Low half of rt into the half picked by lane bit 1
        memWrData.halves[lane[1]] = dStoreValue[halfWidth-1:0];
        memByteEn                 = lane[1] ? 4'b1100 : 4'b0011;
      end
      widthByte: begin
        memWrData.bytes[lane] = dStoreValue[byteWidth-1:0];
        memByteEn             = byteEnWidth'(1) << lane;
      end
      default: ;
    endcase
  end

  dataMemory u_dataMemory (
    .Clk       (Clk),
    .rstN      (rstN),
    .memIdx    (memIdx),
    .memWrData (memWrData),
    .memByteEn (memByteEn),
    .memWrite  (memWrite),
    .memRead   (memRead),
    .memRdData (aReadWord)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Load control, aligned with the registered read word
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      aValid <= 1'b0;
    end else begin
      // Stores and bubbles end here
      aValid <= memRead;
    end
  end

  always_ff @(posedge Clk) begin
    aUnsigned <= dUnsigned;
    aWidth    <= dWidth;
    aLane     <= lane;
    aReg      <= dReg;
  end

  // Decode keeps load and store exclusive
  noReadWrite: assert property (@(posedge Clk) disable iff (!rstN)
    !(memWrite && memRead));

endmodule

/* memDecodeStage.sv */
`timescale 1ns/1ps

module memDecodeStage
  import mipsIsaPkg::*;
(
  input  logic                   Clk,
  input  logic                   rstN,
  input  logic                   instValid,
  input  logic [instWidth-1:0]   instWord,
  input  logic [31:0]            baseValue,
  input  logic [31:0]            storeValue,
  output logic                   dValid,
  output logic                   dIsStore,
  output logic                   dIsLoad,
  output logic                   dUnsigned,
  output logic [1:0]             dWidth,
  output logic [31:0]            dAddr,
  output logic [31:0]            dStoreValue,
  output logic [regIdxWidth-1:0] dReg
);

  logic [opWidth-1:0]  opcode;
  logic [immWidth-1:0] offset;
  logic [31:0]         effAddr;
  logic                nextIsLoad;
  logic                nextIsStore;
  logic                nextUnsigned;
  logic [1:0]          nextWidth;

  assign opcode = instWord[opcodeMsb:opcodeLsb];
  assign offset = instWord[immMsb:immLsb];

  // Base plus sign-extended 16-bit offset
  assign effAddr = baseValue + {{(32-immWidth){offset[immWidth-1]}}, offset};

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    nextIsLoad  = 1'b0;
    nextIsStore = 1'b0;
    // Anything outside the eight memory opcodes leaves both flags low
    case (opcode)
      opLb, opLh, opLw, opLbu, opLhu: nextIsLoad = 1'b1;
      opSb, opSh, opSw:               nextIsStore = 1'b1;
      default: ;
    endcase

    case (opcode)
      opLb, opLbu, opSb: nextWidth = widthByte;
      opLh, opLhu, opSh: nextWidth = widthHalf;
      default:           nextWidth = widthWord;
    endcase

    // Only LBU and LHU zero-extend
    nextUnsigned = (opcode == opLbu) || (opcode == opLhu);
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stage register
  ////////////////////////////////////////////////////////////////////////////

  // Control flags
  always_ff @(posedge Clk or negedge rstN) begin
    if (!rstN) begin
      dValid   <= 1'b0;
      dIsLoad  <= 1'b0;
      dIsStore <= 1'b0;
    end else begin
      dValid   <= instValid;
      dIsLoad  <= instValid & nextIsLoad;
      dIsStore <= instValid & nextIsStore;
    end
  end

  // Payload, only meaningful alongside the flags above
  always_ff @(posedge Clk) begin
    dWidth      <= nextWidth;
    dUnsigned   <= nextUnsigned;
    dAddr       <= effAddr;
    dStoreValue <= storeValue;
    dReg        <= instWord[rtMsb:rtLsb];
  end

  // Halfword needs bit 0 clear, word needs both low bits clear
  alignedAccess: assert property (@(posedge Clk) disable iff (!rstN)
    (dValid && (dIsLoad || dIsStore)) |->
      ((dWidth != widthHalf) || !dAddr[0]) &&
      ((dWidth != widthWord) || (dAddr[1:0] == 2'b00)));

endmodule

/* mipsIsaPkg.sv */
package mipsIsaPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Instruction word layout
  ////////////////////////////////////////////////////////////////////////////

  localparam int instWidth   = 32;
  localparam int regIdxWidth = 5;
  localparam int opWidth     = 6;
  localparam int immWidth    = 16;

  // Bit positions inside the 32-bit I-type word
  localparam int opcodeMsb = 31;
  localparam int opcodeLsb = 26;
  localparam int rsMsb     = 25;
  localparam int rsLsb     = 21;
  localparam int rtMsb     = 20;
  localparam int rtLsb     = 16;
  localparam int immMsb    = 15;
  localparam int immLsb    = 0;

  ////////////////////////////////////////////////////////////////////////////
  // Memory opcodes
  ////////////////////////////////////////////////////////////////////////////

  // Loads
  localparam logic [opWidth-1:0] opLb  = 6'h20;
  localparam logic [opWidth-1:0] opLh  = 6'h21;
  localparam logic [opWidth-1:0] opLw  = 6'h23;
  localparam logic [opWidth-1:0] opLbu = 6'h24;
  localparam logic [opWidth-1:0] opLhu = 6'h25;

  // Stores
  localparam logic [opWidth-1:0] opSb  = 6'h28;
  localparam logic [opWidth-1:0] opSh  = 6'h29;
  localparam logic [opWidth-1:0] opSw  = 6'h2B;

  // Access width codes, shared by load and store paths
  // Code 11 is never produced
  localparam logic [1:0] widthWord = 2'b00;
  localparam logic [1:0] widthHalf = 2'b01;
  localparam logic [1:0] widthByte = 2'b10;

endpackage

/* run.sh */
#!/bin/sh
# Build the Verilator model of the testbench, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f loadStorePipe.f \
  --top-module loadStorePipe_tb -o simv > build.log 2>&1 &&
  ./obj_dir/simv > sim.log 2>&1 ||
  echo "Build or simulation returned an error, see build.log and sim.log"

grep -q "^Test OK$" sim.log && echo "PASS" ||
  { echo "FAIL"; exit 1; }

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock (
  output logic Clk,
  output logic rstN
);

  localparam int halfPeriod  = 2;
  localparam int resetCycles = 8;

  // 4 ns clock
  initial begin
    Clk = 1'b0;
    forever #halfPeriod Clk = ~Clk;
  end

  // Reset held low for the first eight rising edges
  initial begin
    rstN = 1'b0;
    repeat (resetCycles) @(posedge Clk);
    rstN <= 1'b1;
  end

endmodule
